// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := tb_cop_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
cop_pkg.sv
cop_decode.sv
cop_issue.sv
cop_cprs.sv
cop_palu.sv
cop_rng.sv
cop_writeback.sv
cop_top.sv
cop_chk.sv
tb_cop_top.sv

// File: cop_chk.sv
/*
 * Handshake assertions bound into cop_top. Checked only out of reset.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_chk (
    input logic g_clk,
    input logic g_resetn,
    input logic cpu_insn_req,
    input logic cpu_insn_ack,
    input logic cop_insn_ack,
    input logic cop_insn_rsp
);

    // Ready and busy never overlap
    ack_rsp_exclusive: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("cop_insn_ack and cop_insn_rsp high together");

    // Response held until the CPU takes it
    rsp_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp)
        else $error("cop_insn_rsp dropped before retirement");

    rsp_after_accept: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cpu_insn_req && cop_insn_ack |=> $rose(cop_insn_rsp))
        else $error("cop_insn_rsp did not rise one cycle after acceptance");

endmodule

bind cop_top cop_chk u_chk (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .cpu_insn_req (cpu_insn_req),
    .cpu_insn_ack (cpu_insn_ack),
    .cop_insn_ack (cop_insn_ack),
    .cop_insn_rsp (cop_insn_rsp)
);

`default_nettype wire

// File: cop_cprs.sv
/*
 * Sixteen 32-bit CPRs, cleared by reset. Two combinational read ports,
 * one write port with byte enables. Reads see the old value on a write cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_cprs
    import cop_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  cpr_addr_t crs1_addr,
    input  cpr_addr_t crs2_addr,
    input  ben_t      crd_wen,     // Per-byte write enable
    input  cpr_addr_t crd_addr,
    input  word_t     crd_wdata,
    output word_t     crs1_rdata,
    output word_t     crs2_rdata
);

    word_t cprs [16];

    assign crs1_rdata = cprs[crs1_addr];
    assign crs2_rdata = cprs[crs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int r = 0; r < 16; r++) begin
                cprs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (crd_wen[b]) begin
                    cprs[crd_addr][8*b +: 8] <= crd_wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cop_decode.sv
/*
 * Combinational decoder. Any wrong opcode, unsupported class and subclass pair,
 * or bad pack width in the packed class raises exception.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_decode
    import cop_pkg::*;
(
    input  word_t     insn_enc,    // Encoding straight from CPU
    output logic      exception,   // Illegal instruction
    output iclass_t   iclass,
    output sclass_t   subclass,
    output pw_t       pw,
    output cpr_addr_t crs1,
    output cpr_addr_t crs2,
    output cpr_addr_t crd,
    output gpr_addr_t rd,
    output logic      gpr_wen      // Result goes to a GPR
);

    logic opcode_ok;               // Custom opcode match
    logic pw_ok;                   // One of the three pack widths
    logic pair_ok;                 // Class and subclass supported

    assign iclass   = insn_enc[iclass_lsb +: 4];
    assign subclass = insn_enc[sclass_lsb +: 3];
    assign pw       = insn_enc[pw_lsb +: 3];
    assign crs1     = insn_enc[crs1_lsb +: 4];
    assign crs2     = insn_enc[crs2_lsb +: 4];
    assign rd       = insn_enc[rd_lsb +: 5];
    assign crd      = insn_enc[rd_lsb +: 4];    // Low bits of rd field

    assign opcode_ok = insn_enc[6:0] == cop_opcode;
    assign pw_ok     = pw inside {pw_32, pw_16, pw_8};

    always_comb begin
        case (iclass)
            iclass_move:    pair_ok = subclass inside {sclass_gpr2xcr, sclass_xcr2gpr};
            iclass_bitwise: pair_ok = subclass inside {sclass_and, sclass_or, sclass_xor};
            iclass_packed:  pair_ok = pw_ok && (subclass inside {sclass_padd, sclass_psub});
            iclass_random:  pair_ok = subclass inside {sclass_rseed, sclass_rsamp,
                                                       sclass_rtest};
            default:        pair_ok = 1'b0;      // Unknown class
        endcase
    end

    assign exception = !(opcode_ok && pair_ok);

    // Only xcr2gpr and rtest return a GPR value
    assign gpr_wen = (iclass == iclass_move   && subclass == sclass_xcr2gpr) ||
                     (iclass == iclass_random && subclass == sclass_rtest);

endmodule

`default_nettype wire

// File: cop_issue.sv
/*
 * CPU handshake FSM and unit dispatch. One instruction in flight at a time.
 * Every unit finishes in the accept cycle, so rsp rises on the accept edge.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_issue
    import cop_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      cpu_insn_req,
    input  word_t     cpu_insn_enc,
    input  logic      cpu_insn_ack,   // CPU takes the response
    input  logic      palu_idone,
    input  logic      rng_idone,
    output logic      cop_insn_ack,   // Ready to accept
    output logic      cop_insn_rsp,   // Result available
    output logic      palu_ivalid,
    output logic      rng_ivalid,
    output logic      insn_finish,    // Writeback strobe
    output logic      exception,
    output logic      gpr_wen,
    output sclass_t   subclass,
    output pw_t       pw,
    output cpr_addr_t crs1,
    output cpr_addr_t crs2,
    output cpr_addr_t crd,
    output gpr_addr_t rd
);

    typedef enum logic [1:0] {st_idle, st_waiting, st_finished} state_t;

    state_t  state, state_nxt;
    logic    ack_nxt, rsp_nxt;
    logic    insn_accept;              // Request meets acknowledge
    logic    insn_retired;             // Response taken by CPU
    iclass_t iclass;

    cop_decode u_decode (
        .insn_enc  (cpu_insn_enc),
        .exception (exception),
        .iclass    (iclass),
        .subclass  (subclass),
        .pw        (pw),
        .crs1      (crs1),
        .crs2      (crs2),
        .crd       (crd),
        .rd        (rd),
        .gpr_wen   (gpr_wen)
    );

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;

    // One valid per unit, legal instructions only
    assign palu_ivalid = insn_accept && !exception &&
                         (iclass inside {iclass_move, iclass_bitwise, iclass_packed});
    assign rng_ivalid  = insn_accept && !exception && iclass == iclass_random;
    assign insn_finish = palu_idone || rng_idone || (insn_accept && exception);

    always_comb begin
        state_nxt = state;
        ack_nxt   = 1'b0;
        rsp_nxt   = 1'b0;
        case (state)
            st_idle: begin
                state_nxt = st_waiting;
                ack_nxt   = 1'b1;
            end
            st_waiting: begin
                if (insn_finish) begin
                    state_nxt = st_finished;  // Result registered this edge
                    rsp_nxt   = 1'b1;
                end else begin
                    ack_nxt   = 1'b1;
                end
            end
            default: begin                    // st_finished
                if (insn_retired) begin
                    state_nxt = st_waiting;
                    ack_nxt   = 1'b1;
                end else begin
                    rsp_nxt   = 1'b1;         // Hold under back-pressure
                end
            end
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= st_idle;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
        end else begin
            state        <= state_nxt;
            cop_insn_ack <= ack_nxt;
            cop_insn_rsp <= rsp_nxt;
        end
    end

endmodule

`default_nettype wire

// File: cop_palu.sv
/*
 * Move, bitwise and packed add/subtract, all combinational.
 * Outputs are zero when idle. Packed carries stop at lane borders set by pw.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_palu
    import cop_pkg::*;
(
    input  logic    palu_ivalid,
    input  sclass_t subclass,
    input  pw_t     pw,
    input  word_t   gpr_rs1,          // CPU rs1 for gpr2xcr
    input  word_t   palu_rs1,         // crs1 data
    input  word_t   palu_rs2,         // crs2 data
    output logic    palu_idone,
    output ben_t    palu_cpr_rd_ben,
    output word_t   palu_cpr_rd_wdata
);

    logic  is_sub;
    logic  [3:0] lane_start;          // Byte that opens a new lane
    word_t rhs;                       // Second addend, inverted for sub
    word_t packed_res;
    word_t result;

    assign is_sub = subclass == sclass_psub;
    assign rhs    = is_sub ? ~palu_rs2 : palu_rs2;

    always_comb begin
        case (pw)
            pw_16:   lane_start = 4'b0101;
            pw_8:    lane_start = 4'b1111;
            default: lane_start = 4'b0001;  // pw_32
        endcase
    end

    // Byte-serial add, carry reseeded at each lane start
    always_comb begin
        logic       carry;
        logic [8:0] sum;
        carry      = is_sub;
        packed_res = '0;
        for (int b = 0; b < 4; b++) begin
            if (lane_start[b]) carry = is_sub;    // Two's complement +1
            sum = {1'b0, palu_rs1[8*b +: 8]} + {1'b0, rhs[8*b +: 8]} + {8'd0, carry};
            packed_res[8*b +: 8] = sum[7:0];
            carry = sum[8];
        end
    end

    always_comb begin
        case (subclass)
            sclass_gpr2xcr: result = gpr_rs1;
            sclass_xcr2gpr: result = palu_rs1;   // For GPR path
            sclass_and:     result = palu_rs1 & palu_rs2;
            sclass_or:      result = palu_rs1 | palu_rs2;
            sclass_xor:     result = palu_rs1 ^ palu_rs2;
            default:        result = packed_res; // padd, psub
        endcase
    end

    assign palu_idone        = palu_ivalid;
    assign palu_cpr_rd_wdata = palu_ivalid ? result : '0;
    assign palu_cpr_rd_ben   = (palu_ivalid && subclass != sclass_xcr2gpr) ? 4'hf : 4'h0;

endmodule

`default_nettype wire

// File: cop_pkg.sv
/*
 * Shared widths, encoding fields, codes and RNG constants for the co-processor.
 * PALU subclass codes are unique across move, bitwise and packed classes,
 * so the PALU decodes on subclass alone. Random subclasses reuse low codes.
 */
`default_nettype none

package cop_pkg;

    localparam int xlen = 32;                        // Data width

    typedef logic [xlen-1:0] word_t;                 // Data word
    typedef logic [3:0]      cpr_addr_t;             // CPR index
    typedef logic [4:0]      gpr_addr_t;             // GPR index
    typedef logic [3:0]      ben_t;                  // Byte write enables
    typedef logic [2:0]      result_t;               // Result code to CPU
    typedef logic [3:0]      iclass_t;               // Instruction class
    typedef logic [2:0]      sclass_t;               // Instruction subclass
    typedef logic [2:0]      pw_t;                   // Pack width

    // Field positions in the encoding
    localparam int iclass_lsb = 28;                  // Bits 31:28
    localparam int sclass_lsb = 25;                  // Bits 27:25
    localparam int crs2_lsb   = 20;                  // Bits 23:20
    localparam int crs1_lsb   = 16;                  // Bits 19:16
    localparam int pw_lsb     = 12;                  // Bits 14:12
    localparam int rd_lsb     = 7;                   // rd 11:7, crd 10:7

    localparam logic [6:0] cop_opcode = 7'b0001011;  // custom-0

    localparam iclass_t iclass_move    = 4'd0;
    localparam iclass_t iclass_bitwise = 4'd1;
    localparam iclass_t iclass_packed  = 4'd2;
    localparam iclass_t iclass_random  = 4'd3;

    localparam sclass_t sclass_gpr2xcr = 3'd0;       // crd <= rs1
    localparam sclass_t sclass_xcr2gpr = 3'd1;       // rd <= crs1
    localparam sclass_t sclass_and     = 3'd2;
    localparam sclass_t sclass_or      = 3'd3;
    localparam sclass_t sclass_xor     = 3'd4;
    localparam sclass_t sclass_padd    = 3'd5;
    localparam sclass_t sclass_psub    = 3'd6;
    localparam sclass_t sclass_rseed   = 3'd0;       // Random class only
    localparam sclass_t sclass_rsamp   = 3'd1;
    localparam sclass_t sclass_rtest   = 3'd2;

    localparam pw_t pw_32 = 3'd0;                    // One lane
    localparam pw_t pw_16 = 3'd1;                    // Two lanes
    localparam pw_t pw_8  = 3'd2;                    // Four lanes

    localparam result_t result_success = 3'd0;
    localparam result_t result_bad_ins = 3'd1;

    localparam word_t rng_reset_state = 32'h6a09_e667;  // Nonzero LFSR seed
    localparam word_t rng_taps        = 32'h8020_0003;  // Galois feedback mask
    localparam word_t rng_healthy     = 32'd1;          // RTEST answer

endpackage

`default_nettype wire

// File: cop_rng.sv
/*
 * Galois LFSR random unit. rseed loads crs1, rsamp writes the state to crd
 * and steps it, rtest returns a fixed healthy word. Not a secure source.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_rng
    import cop_pkg::*;
(
    input  logic    g_clk,
    input  logic    g_resetn,
    input  logic    rng_ivalid,
    input  sclass_t subclass,
    input  word_t   rng_rs1,           // crs1 data, seed source
    output logic    rng_idone,
    output ben_t    rng_cpr_rd_ben,
    output word_t   rng_cpr_rd_wdata
);

    word_t lfsr;
    word_t lfsr_step;                  // State after one shift
    logic  do_seed, do_samp, do_test;

    assign do_seed = rng_ivalid && subclass == sclass_rseed;
    assign do_samp = rng_ivalid && subclass == sclass_rsamp;
    assign do_test = rng_ivalid && subclass == sclass_rtest;

    // Shift right, fold taps in when a one falls out
    assign lfsr_step = {1'b0, lfsr[xlen-1:1]} ^ (lfsr[0] ? rng_taps : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= rng_reset_state;
        end else if (do_seed) begin
            lfsr <= rng_rs1;
        end else if (do_samp) begin
            lfsr <= lfsr_step;
        end
    end

    assign rng_idone        = rng_ivalid;
    assign rng_cpr_rd_ben   = do_samp ? 4'hf : 4'h0;   // Only rsamp writes a CPR
    assign rng_cpr_rd_wdata = do_samp ? lfsr :
                              do_test ? rng_healthy : '0;

endmodule

`default_nettype wire

// File: cop_top.sv
/*
 * Co-processor top. CPU request/acknowledge in, registered GPR result out.
 * No memory port; all instructions complete in the accept cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_top
    import cop_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      cpu_insn_req,
    input  word_t     cpu_insn_enc,
    input  word_t     cpu_rs1,
    input  logic      cpu_insn_ack,
    output logic      cop_insn_ack,
    output logic      cop_insn_rsp,
    output logic      cop_wen,
    output gpr_addr_t cop_waddr,
    output word_t     cop_wdata,
    output result_t   cop_result
);

    logic      palu_ivalid, palu_idone;
    logic      rng_ivalid, rng_idone;
    logic      insn_finish, exception, gpr_wen;
    sclass_t   subclass;
    pw_t       pw;
    cpr_addr_t crs1, crs2, crd;
    gpr_addr_t rd;
    word_t     crs1_rdata, crs2_rdata;
    ben_t      crd_wen, palu_ben, rng_ben;
    cpr_addr_t crd_addr;
    word_t     crd_wdata, palu_wdata, rng_wdata;

    cop_issue u_issue (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .cpu_insn_req(cpu_insn_req), .cpu_insn_enc(cpu_insn_enc),
        .cpu_insn_ack(cpu_insn_ack), .palu_idone(palu_idone), .rng_idone(rng_idone),
        .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp),
        .palu_ivalid(palu_ivalid), .rng_ivalid(rng_ivalid),
        .insn_finish(insn_finish), .exception(exception), .gpr_wen(gpr_wen),
        .subclass(subclass), .pw(pw), .crs1(crs1), .crs2(crs2), .crd(crd), .rd(rd)
    );

    cop_cprs u_cprs (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .crs1_addr(crs1), .crs2_addr(crs2),
        .crd_wen(crd_wen), .crd_addr(crd_addr), .crd_wdata(crd_wdata),
        .crs1_rdata(crs1_rdata), .crs2_rdata(crs2_rdata)
    );

    cop_palu u_palu (
        .palu_ivalid(palu_ivalid), .subclass(subclass), .pw(pw),
        .gpr_rs1(cpu_rs1), .palu_rs1(crs1_rdata), .palu_rs2(crs2_rdata),
        .palu_idone(palu_idone), .palu_cpr_rd_ben(palu_ben),
        .palu_cpr_rd_wdata(palu_wdata)
    );

    cop_rng u_rng (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .rng_ivalid(rng_ivalid), .subclass(subclass), .rng_rs1(crs1_rdata),
        .rng_idone(rng_idone), .rng_cpr_rd_ben(rng_ben), .rng_cpr_rd_wdata(rng_wdata)
    );

    cop_writeback u_writeback (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .insn_finish(insn_finish), .exception(exception), .gpr_wen(gpr_wen),
        .crd(crd), .rd(rd),
        .palu_cpr_rd_ben(palu_ben), .palu_cpr_rd_wdata(palu_wdata),
        .rng_cpr_rd_ben(rng_ben), .rng_cpr_rd_wdata(rng_wdata),
        .crd_wen(crd_wen), .crd_addr(crd_addr), .crd_wdata(crd_wdata),
        .cop_wen(cop_wen), .cop_waddr(cop_waddr), .cop_wdata(cop_wdata),
        .cop_result(cop_result)
    );

endmodule

`default_nettype wire

// File: cop_writeback.sv
/*
 * Merges unit outputs into the CPR write port and registers the GPR result.
 * Units drive zero when idle, so plain OR selects the one that ran.
 */
`timescale 1ns/1ps
`default_nettype none

module cop_writeback
    import cop_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      insn_finish,       // Accept cycle of any instruction
    input  logic      exception,
    input  logic      gpr_wen,
    input  cpr_addr_t crd,
    input  gpr_addr_t rd,
    input  ben_t      palu_cpr_rd_ben,
    input  word_t     palu_cpr_rd_wdata,
    input  ben_t      rng_cpr_rd_ben,
    input  word_t     rng_cpr_rd_wdata,
    output ben_t      crd_wen,
    output cpr_addr_t crd_addr,
    output word_t     crd_wdata,
    output logic      cop_wen,
    output gpr_addr_t cop_waddr,
    output word_t     cop_wdata,
    output result_t   cop_result
);

    assign crd_wen   = palu_cpr_rd_ben | rng_cpr_rd_ben;
    assign crd_addr  = crd;
    assign crd_wdata = palu_cpr_rd_wdata | rng_cpr_rd_wdata;  // Also GPR data

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_wen    <= 1'b0;
            cop_result <= result_success;
        end else if (insn_finish) begin
            cop_wen    <= gpr_wen && !exception;
            cop_result <= exception ? result_bad_ins : result_success;
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_finish) begin
            cop_waddr <= rd;
            cop_wdata <= crd_wdata;
        end
    end

endmodule

`default_nettype wire

// File: tb_cop_top.sv
/*
 * Directed testbench for cop_top. Keeps its own CPR and LFSR model.
 * One instruction in flight; stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cop_top
    import cop_pkg::*;
();

    localparam int clk_period = 4;
    localparam int n_rounds   = 4;                     // Rounds of bitwise and packed ops
    // Instructions per test, in run order
    localparam int n_insns    = 3 + 32 + 9 * 4 * n_rounds + 17 + 9 + 3;
    localparam int timeout_ns = n_insns * 200 * clk_period;

    logic      g_clk = 1'b0;
    logic      g_resetn;
    logic      cpu_insn_req;
    word_t     cpu_insn_enc;
    word_t     cpu_rs1;
    logic      cpu_insn_ack;
    logic      cop_insn_ack;
    logic      cop_insn_rsp;
    logic      cop_wen;
    gpr_addr_t cop_waddr;
    word_t     cop_wdata;
    result_t   cop_result;

    word_t       cpr_model [16];                       // Expected CPR contents
    word_t       lfsr_model;                           // Expected RNG state
    integer      seed         = 18345;
    int unsigned cycle_count  = 0;
    int unsigned accept_cycle = 0;                     // Cycle of the last accept edge

    always #(clk_period / 2) g_clk = ~g_clk;

    always @(posedge g_clk) cycle_count <= cycle_count + 1;

    cop_top u_cop_top (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cpu_insn_ack (cpu_insn_ack),
        .cop_insn_ack (cop_insn_ack),
        .cop_insn_rsp (cop_insn_rsp),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_run("A data word from the DUT is wrong");
        end
    endtask

    task automatic check_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run("The result code from the DUT is wrong");
        end
    endtask

    task automatic check_addr(input string name, input gpr_addr_t got, input gpr_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run("The GPR address from the DUT is wrong");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run("A handshake or enable level from the DUT is wrong");
        end
    endtask

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    // Field layout: class, subclass, 0, crs2, crs1, 0, pw, rd, opcode
    function automatic word_t encode_insn(input iclass_t c, input sclass_t s, input pw_t p,
                                          input cpr_addr_t crs1, input cpr_addr_t crs2,
                                          input gpr_addr_t rd);
        return {c, s, 1'b0, crs2, crs1, 1'b0, p, rd, cop_opcode};
    endfunction

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ rng_taps) : (s >> 1);
    endfunction

    // Lane-wise add or subtract, each lane wraps on its own
    function automatic word_t packed_model(input word_t a, input word_t b,
                                           input int lane_bits, input logic sub);
        word_t       res;
        logic [63:0] mask, la, lb, lr;
        res  = '0;
        mask = (64'd1 << lane_bits) - 64'd1;
        for (int l = 0; l < 32 / lane_bits; l++) begin
            la  = {32'd0, a >> (l * lane_bits)} & mask;
            lb  = {32'd0, b >> (l * lane_bits)} & mask;
            lr  = (sub ? la - lb : la + lb) & mask;
            res = res | (lr[31:0] << (l * lane_bits));
        end
        return res;
    endfunction

    // Returns in the cycle before retirement, with the result outputs valid
    task automatic issue_insn(input word_t enc, input word_t rs1, input int stall);
        logic      held_wen;
        gpr_addr_t held_waddr;
        word_t     held_wdata;
        result_t   held_result;
        @(posedge g_clk);
        cpu_insn_req <= 1'b1;
        cpu_insn_enc <= enc;
        cpu_rs1      <= rs1;
        cpu_insn_ack <= (stall == 0);
        @(negedge g_clk);
        while (!cop_insn_ack) @(negedge g_clk);
        @(posedge g_clk);                                 // Accept edge
        if (stall > 0) begin
            cpu_insn_enc <= {enc[31:7], 7'b0110011};    // Illegal, must not be taken
        end else begin
            cpu_insn_req <= 1'b0;
        end
        @(negedge g_clk);
        accept_cycle = cycle_count;
        check_bit("cop_insn_rsp", cop_insn_rsp, 1'b1);
        check_bit("cop_insn_ack", cop_insn_ack, 1'b0);
        held_wen    = cop_wen;
        held_waddr  = cop_waddr;
        held_wdata  = cop_wdata;
        held_result = cop_result;
        for (int i = 0; i < stall; i++) begin
            @(posedge g_clk);
            if (i == stall - 1) begin
                cpu_insn_req <= 1'b0;
                cpu_insn_ack <= 1'b1;                   // Retires on the next edge
            end
            @(negedge g_clk);
            check_bit("cop_insn_rsp", cop_insn_rsp, 1'b1);
            check_bit("cop_insn_ack", cop_insn_ack, 1'b0);
            check_bit("cop_wen", cop_wen, held_wen);
            check_addr("cop_waddr", cop_waddr, held_waddr);
            check_word("cop_wdata", cop_wdata, held_wdata);
            check_result("cop_result", cop_result, held_result);
        end
    endtask

    task automatic write_cpr(input cpr_addr_t crd, input word_t value);
        issue_insn(encode_insn(iclass_move, sclass_gpr2xcr, pw_32, 4'd0, 4'd0, {1'b0, crd}),
                   value, 0);
        cpr_model[crd] = value;
        check_bit("cop_wen", cop_wen, 1'b0);
        check_result("cop_result", cop_result, result_success);
    endtask

    task automatic expect_cpr(input cpr_addr_t crs1, input gpr_addr_t rd, input int stall);
        issue_insn(encode_insn(iclass_move, sclass_xcr2gpr, pw_32, crs1, 4'd0, rd),
                   rand_word(), stall);
        check_bit("cop_wen", cop_wen, 1'b1);
        check_addr("cop_waddr", cop_waddr, rd);
        check_word("cop_wdata", cop_wdata, cpr_model[crs1]);
        check_result("cop_result", cop_result, result_success);
    endtask

    task automatic run_plain(input word_t enc);
        issue_insn(enc, rand_word(), 0);
        check_bit("cop_wen", cop_wen, 1'b0);
        check_result("cop_result", cop_result, result_success);
    endtask

    task automatic expect_bad_ins(input word_t enc);
        issue_insn(enc, rand_word(), 0);
        check_bit("cop_wen", cop_wen, 1'b0);
        check_result("cop_result", cop_result, result_bad_ins);
    endtask

    task automatic reset_and_handshake();
        int unsigned first_accept;
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_bit("cop_insn_ack", cop_insn_ack, 1'b0);
        check_bit("cop_insn_rsp", cop_insn_rsp, 1'b0);
        check_bit("cop_wen", cop_wen, 1'b0);
        check_result("cop_result", cop_result, result_success);
        @(negedge g_clk);
        check_bit("cop_insn_ack", cop_insn_ack, 1'b1);    // One cycle after release
        write_cpr(4'd1, 32'h1234_5678);
        first_accept = accept_cycle;
        write_cpr(4'd2, rand_word());
        check_word("accept interval", word_t'(accept_cycle - first_accept), 32'd2);
        expect_cpr(4'd1, 5'd3, 0);
    endtask

    task automatic move_round_trip();
        for (int r = 0; r < 16; r++) begin
            write_cpr(4'(r), rand_word());
        end
        for (int r = 0; r < 16; r++) begin
            expect_cpr(4'(r), 5'(31 - r), 0);
        end
    endtask

    task automatic bitwise_and_packed();
        word_t     a, b, w, expv;
        cpr_addr_t c1, c2, c3;
        iclass_t   cls;
        sclass_t   sc;
        pw_t       p;
        int        lane_bits;
        for (int round = 0; round < n_rounds; round++) begin
            for (int k = 0; k < 9; k++) begin
                w         = rand_word();
                c1        = w[3:0];
                c2        = w[7:4];
                c3        = w[11:8];
                cls       = (k < 3) ? iclass_bitwise : iclass_packed;
                sc        = (k == 0) ? sclass_and : (k == 1) ? sclass_or :
                            (k == 2) ? sclass_xor : (k < 6) ? sclass_padd : sclass_psub;
                lane_bits = (k < 3) ? 32 : (((k - 3) % 3 == 0) ? 32 :
                                            ((k - 3) % 3 == 1) ? 16 : 8);
                p         = (lane_bits == 32) ? pw_32 : (lane_bits == 16) ? pw_16 : pw_8;
                a         = rand_word();
                b         = rand_word();
                if (round == 0) begin                     // Carry and borrow in every lane
                    a = (sc == sclass_psub) ? 32'h0000_0000 : 32'hffff_ffff;
                    b = 32'h0101_0101;
                end
                write_cpr(c1, a);
                write_cpr(c2, b);
                a = cpr_model[c1];                         // c1 may equal c2
                b = cpr_model[c2];
                case (k)
                    0:       expv = a & b;
                    1:       expv = a | b;
                    2:       expv = a ^ b;
                    default: expv = packed_model(a, b, lane_bits, sc == sclass_psub);
                endcase
                run_plain(encode_insn(cls, sc, p, c1, c2, {1'b0, c3}));
                cpr_model[c3] = expv;
                expect_cpr(c3, 5'(k), 0);
            end
        end
    endtask

    task automatic random_unit();
        word_t     seed_val;
        cpr_addr_t dst;
        issue_insn(encode_insn(iclass_random, sclass_rtest, pw_32, 4'd0, 4'd0, 5'd17),
                   rand_word(), 0);
        check_bit("cop_wen", cop_wen, 1'b1);
        check_addr("cop_waddr", cop_waddr, 5'd17);
        check_word("cop_wdata", cop_wdata, rng_healthy);
        check_result("cop_result", cop_result, result_success);
        dst = 4'd9;                                        // First sample is the reset state
        run_plain(encode_insn(iclass_random, sclass_rsamp, pw_32, 4'd0, 4'd0, {1'b0, dst}));
        cpr_model[dst] = lfsr_model;
        lfsr_model     = lfsr_next(lfsr_model);
        expect_cpr(dst, 5'd9, 0);
        seed_val = rand_word() | 32'h1;
        write_cpr(4'd4, seed_val);
        run_plain(encode_insn(iclass_random, sclass_rseed, pw_32, 4'd4, 4'd0, 5'd0));
        lfsr_model = cpr_model[4'd4];
        for (int i = 0; i < 6; i++) begin
            dst = 4'(i + 5);
            run_plain(encode_insn(iclass_random, sclass_rsamp, pw_32, 4'd0, 4'd0, {1'b0, dst}));
            cpr_model[dst] = lfsr_model;
            lfsr_model     = lfsr_next(lfsr_model);
            expect_cpr(dst, 5'(i), 0);
        end
    endtask

    task automatic illegal_insns();
        word_t     enc;
        cpr_addr_t victim;
        victim = 4'd6;
        write_cpr(victim, rand_word());
        enc      = encode_insn(iclass_move, sclass_gpr2xcr, pw_32, 4'd0, 4'd0, {1'b0, victim});
        enc[6:0] = 7'b0110011;                             // Wrong opcode
        expect_bad_ins(enc);
        enc      = encode_insn(iclass_move, sclass_xcr2gpr, pw_32, victim, 4'd0, 5'd12);
        enc[6:0] = 7'b0101011;                             // Would write a GPR
        expect_bad_ins(enc);
        expect_bad_ins(encode_insn(iclass_move, 3'd7, pw_32, 4'd1, 4'd2, {1'b0, victim}));
        expect_bad_ins(encode_insn(iclass_bitwise, sclass_padd, pw_32, 4'd1, 4'd2,
                                   {1'b0, victim}));
        expect_bad_ins(encode_insn(iclass_random, 3'd5, pw_32, 4'd1, 4'd2, {1'b0, victim}));
        expect_bad_ins(encode_insn(iclass_packed, sclass_padd, 3'd3, 4'd1, 4'd2,
                                   {1'b0, victim}));       // Bad pack width
        expect_bad_ins(encode_insn(4'd9, sclass_and, pw_32, 4'd1, 4'd2, {1'b0, victim}));
        expect_cpr(victim, 5'd1, 0);
    endtask

    task automatic back_pressure();
        word_t value;
        value = rand_word();
        issue_insn(encode_insn(iclass_move, sclass_gpr2xcr, pw_32, 4'd0, 4'd0, 5'd11),
                   value, 3);
        cpr_model[11] = value;
        check_bit("cop_wen", cop_wen, 1'b0);
        check_result("cop_result", cop_result, result_success);
        expect_cpr(4'd11, 5'd21, 6);
        expect_cpr(4'd3, 5'd30, 4);
    endtask

    initial begin
        #(timeout_ns);
        fail_run("Timeout: the tests did not finish in the allowed time");
    end

    initial begin
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b1;
        for (int r = 0; r < 16; r++) begin
            cpr_model[r] = '0;                             // Reset clears the CPRs
        end
        lfsr_model = rng_reset_state;
        reset_and_handshake();
        move_round_trip();
        bitwise_and_packed();
        random_unit();
        illegal_insns();
        back_pressure();
        repeat (4) @(posedge g_clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
